// File: logic/pkt_pkg.sv
// Shared stream types for the dual port packet merge
// Word, sideband and source id types, plus the merger state enum
`default_nettype none

package pkt_pkg;

	// One data byte per beat
	typedef logic [7:0] tdata_t;

	// Per-beat sideband, carried through without change
	typedef logic [1:0] tuser_t;

	// Input port a beat came from
	typedef logic src_id_t;

	// Source id values
	localparam src_id_t SRC_A = 1'b0;
	localparam src_id_t SRC_B = 1'b1;

	// Merger FSM
	// Idle waits for a grant, the other two forward one whole packet
	typedef enum logic [1:0] {
		MERGE_IDLE,
		MERGE_SRC_A,
		MERGE_SRC_B
	} merge_state_t;

endpackage

`default_nettype wire

// File: logic/cdc_vector.sv
// Toggle handshake synchronizer for a multi-bit value
// Source holding register, request and acknowledge synchronizers, destination register
`timescale 1ns/100ps
`default_nettype none

module cdc_vector
#(
	parameter int WIDTH = 8
) (
	input  wire              i_src_clk,
	input  wire              i_src_sresetn,
	input  wire              i_dst_clk,
	input  wire              i_dst_sresetn,
	input  wire [WIDTH-1:0]  i_data,
	output logic [WIDTH-1:0] o_data
);
	// Source side state
	logic [WIDTH-1:0] src_hold;
	logic             req_src;
	logic [1:0]       ack_sync;
	logic             src_idle;

	// Destination side state
	logic [1:0] req_sync;
	logic       ack_dst;
	logic       req_edge;

	// Previous request has come back, so the holding register may change
	assign src_idle = (ack_sync[1] == req_src);

	always_ff @(posedge i_src_clk)
	begin
		if (!i_src_sresetn)
		begin
			req_src  <= 1'b0;
			ack_sync <= '0;
		end
		else
		begin
			// Bring the acknowledge toggle into the source domain
			ack_sync <= {ack_sync[0], ack_dst};
			// New sample goes out with a fresh request edge
			if (src_idle)
				req_src <= ~req_src;
		end
	end

	// Held value stays put while a request is in flight
	always_ff @(posedge i_src_clk)
	begin
		if (src_idle)
			src_hold <= i_data;
	end

	// Request toggle differs from our last acknowledge
	assign req_edge = req_sync[1] ^ ack_dst;

	always_ff @(posedge i_dst_clk)
	begin
		if (!i_dst_sresetn)
		begin
			req_sync <= '0;
			ack_dst  <= 1'b0;
			o_data   <= '0;
		end
		else
		begin
			req_sync <= {req_sync[0], req_src};
			if (req_edge)
			begin
				// Holding register has been stable for two dst cycles here
				o_data  <= src_hold;
				ack_dst <= req_sync[1];
			end
		end
	end

	// Output only moves on a captured request
	a_dst_change_on_req : assert property (
		@(posedge i_dst_clk) disable iff (!i_dst_sresetn)
		!$stable(o_data) |-> $past(req_edge)
	);

endmodule

`default_nettype wire

// File: logic/axis_packet_fifo_async.sv
// Dual clock packet FIFO
// Commits a packet on its last beat, rewinds to packet start on drop
// Pointers cross through two toggle handshake synchronizers
`timescale 1ns/100ps
`default_nettype none

module axis_packet_fifo_async
#(
	parameter int LOG2_DEPTH = 5
) (
	// Write side, input clock domain
	input  wire             i_clk,
	input  wire             i_sresetn,
	input  wire             i_tvalid,
	output logic            o_tready,
	input  pkt_pkg::tdata_t i_tdata,
	input  pkt_pkg::tuser_t i_tuser,
	input  wire             i_tlast,
	input  wire             i_drop,

	// Read side, output clock domain
	input  wire              i_out_clk,
	input  wire              i_out_sresetn,
	input  wire              i_rd_tready,
	output logic             o_rd_tvalid,
	output pkt_pkg::tdata_t  o_rd_tdata,
	output pkt_pkg::tuser_t  o_rd_tuser,
	output logic             o_rd_tlast
);
	import pkt_pkg::*;

	localparam int DEPTH = 2 ** LOG2_DEPTH;

	// Pointer with one extra wrap bit for full and empty detection
	typedef logic [LOG2_DEPTH:0] ptr_t;

	// Occupancy of a full FIFO in pointer width
	localparam ptr_t DEPTH_PTR = {1'b1, {LOG2_DEPTH{1'b0}}};

	// Storage, split by field
	tdata_t mem_data [0:DEPTH-1];
	tuser_t mem_user [0:DEPTH-1];
	logic   mem_last [0:DEPTH-1];

	// Input domain pointers
	ptr_t wr_ptr;
	ptr_t wr_commit;
	ptr_t rd_ptr_in;
	logic full;
	logic wr_take;
	ptr_t in_level;

	// Output domain pointers
	ptr_t rd_ptr;
	ptr_t wr_ptr_out;
	logic rd_empty;
	logic rd_take;
	ptr_t out_level;

	// Only committed packets are shown to the reader
	cdc_vector #(
		.WIDTH(LOG2_DEPTH + 1)
	) u_wr_ptr_sync (
		.i_src_clk     (i_clk),
		.i_src_sresetn (i_sresetn),
		.i_dst_clk     (i_out_clk),
		.i_dst_sresetn (i_out_sresetn),
		.i_data        (wr_commit),
		.o_data        (wr_ptr_out)
	);

	// Read pointer back to the writer, always late so full is pessimistic
	cdc_vector #(
		.WIDTH(LOG2_DEPTH + 1)
	) u_rd_ptr_sync (
		.i_src_clk     (i_out_clk),
		.i_src_sresetn (i_out_sresetn),
		.i_dst_clk     (i_clk),
		.i_dst_sresetn (i_sresetn),
		.i_data        (rd_ptr),
		.o_data        (rd_ptr_in)
	);

	// Full when the addresses match and the wrap bits differ
	assign full = (wr_ptr[LOG2_DEPTH-1:0] == rd_ptr_in[LOG2_DEPTH-1:0]) &&
		(wr_ptr[LOG2_DEPTH] != rd_ptr_in[LOG2_DEPTH]);
	assign o_tready = !full;
	assign wr_take  = i_tvalid && o_tready;

	always_ff @(posedge i_clk)
	begin
		if (!i_sresetn)
		begin
			wr_ptr    <= '0;
			wr_commit <= '0;
		end
		else if (wr_take)
		begin
			if (i_drop)
				// Throw away the open packet
				wr_ptr <= wr_commit;
			else
			begin
				wr_ptr <= wr_ptr + ptr_t'(1);
				// Commit points past the last beat written
				if (i_tlast)
					wr_commit <= wr_ptr + ptr_t'(1);
			end
		end
	end

	// A dropped beat lands in a slot that gets rewound anyway
	always_ff @(posedge i_clk)
	begin
		if (wr_take)
		begin
			mem_data[wr_ptr[LOG2_DEPTH-1:0]] <= i_tdata;
			mem_user[wr_ptr[LOG2_DEPTH-1:0]] <= i_tuser;
			mem_last[wr_ptr[LOG2_DEPTH-1:0]] <= i_tlast;
		end
	end

	// Refill the output word when it is empty or leaving this cycle
	assign rd_empty = (rd_ptr == wr_ptr_out);
	assign rd_take  = !rd_empty && (!o_rd_tvalid || i_rd_tready);

	always_ff @(posedge i_out_clk)
	begin
		if (!i_out_sresetn)
		begin
			rd_ptr      <= '0;
			o_rd_tvalid <= 1'b0;
		end
		else
		begin
			if (i_rd_tready)
				o_rd_tvalid <= 1'b0;
			if (rd_take)
			begin
				o_rd_tvalid <= 1'b1;
				rd_ptr      <= rd_ptr + ptr_t'(1);
			end
		end
	end

	always_ff @(posedge i_out_clk)
	begin
		if (rd_take)
		begin
			o_rd_tdata <= mem_data[rd_ptr[LOG2_DEPTH-1:0]];
			o_rd_tuser <= mem_user[rd_ptr[LOG2_DEPTH-1:0]];
			o_rd_tlast <= mem_last[rd_ptr[LOG2_DEPTH-1:0]];
		end
	end

	// Levels as seen from each side, modulo the wrap bit
	assign in_level  = wr_ptr - rd_ptr_in;
	assign out_level = wr_ptr_out - rd_ptr;

	// Writer never gets more than a full FIFO ahead of the crossed read pointer
	a_no_overfill : assert property (
		@(posedge i_clk) disable iff (!i_sresetn)
		in_level <= DEPTH_PTR
	);

	// Reader never runs past the committed write pointer it has seen
	a_rd_behind_wr : assert property (
		@(posedge i_out_clk) disable iff (!i_out_sresetn)
		out_level <= DEPTH_PTR
	);

endmodule

`default_nettype wire

// File: logic/axis_packet_merge.sv
// Round-robin merger of two packet streams
// Forwards whole packets through a registered output and tags each beat with its source
`timescale 1ns/100ps
`default_nettype none

module axis_packet_merge
(
	input  wire i_clk,
	input  wire i_sresetn,

	// Source A
	input  wire             i_a_tvalid,
	output logic            o_a_tready,
	input  pkt_pkg::tdata_t i_a_tdata,
	input  pkt_pkg::tuser_t i_a_tuser,
	input  wire             i_a_tlast,

	// Source B
	input  wire             i_b_tvalid,
	output logic            o_b_tready,
	input  pkt_pkg::tdata_t i_b_tdata,
	input  pkt_pkg::tuser_t i_b_tuser,
	input  wire             i_b_tlast,

	// Merged output
	input  wire              i_tready,
	output logic             o_tvalid,
	output pkt_pkg::tdata_t  o_tdata,
	output pkt_pkg::tuser_t  o_tuser,
	output logic             o_tlast,
	output pkt_pkg::src_id_t o_src
);
	import pkt_pkg::*;

	merge_state_t state;
	// Winner of the previous grant
	src_id_t      last_src;
	logic         out_free;
	logic         take_a;
	logic         take_b;

	// Output register can accept a beat
	assign out_free = !o_tvalid || i_tready;

	// Ready only toward the granted source
	assign o_a_tready = (state == MERGE_SRC_A) && out_free;
	assign o_b_tready = (state == MERGE_SRC_B) && out_free;
	assign take_a     = i_a_tvalid && o_a_tready;
	assign take_b     = i_b_tvalid && o_b_tready;

	always_ff @(posedge i_clk)
	begin
		if (!i_sresetn)
		begin
			state    <= MERGE_IDLE;
			// A gets the first grant
			last_src <= SRC_B;
			o_tvalid <= 1'b0;
		end
		else
		begin
			// Output word leaves, maybe refilled below
			if (i_tready)
				o_tvalid <= 1'b0;
			if (take_a || take_b)
				o_tvalid <= 1'b1;

			case (state)
				MERGE_IDLE:
				begin
					// Prefer the source that lost last time
					if (last_src == SRC_A)
					begin
						if (i_b_tvalid)
						begin
							state    <= MERGE_SRC_B;
							last_src <= SRC_B;
						end
						else if (i_a_tvalid)
						begin
							state    <= MERGE_SRC_A;
							last_src <= SRC_A;
						end
					end
					else
					begin
						if (i_a_tvalid)
						begin
							state    <= MERGE_SRC_A;
							last_src <= SRC_A;
						end
						else if (i_b_tvalid)
						begin
							state    <= MERGE_SRC_B;
							last_src <= SRC_B;
						end
					end
				end
				// Stay on one source until its packet ends
				MERGE_SRC_A:
				begin
					if (take_a && i_a_tlast)
						state <= MERGE_IDLE;
				end
				MERGE_SRC_B:
				begin
					if (take_b && i_b_tlast)
						state <= MERGE_IDLE;
				end
				default:
				begin
					state <= MERGE_IDLE;
				end
			endcase
		end
	end

	// Output payload
	always_ff @(posedge i_clk)
	begin
		if (take_a)
		begin
			o_tdata <= i_a_tdata;
			o_tuser <= i_a_tuser;
			o_tlast <= i_a_tlast;
			o_src   <= SRC_A;
		end
		else if (take_b)
		begin
			o_tdata <= i_b_tdata;
			o_tuser <= i_b_tuser;
			o_tlast <= i_b_tlast;
			o_src   <= SRC_B;
		end
	end

	// Stalled output holds every field
	a_out_stable : assert property (
		@(posedge i_clk) disable iff (!i_sresetn)
		(o_tvalid && !i_tready) |=> $stable({o_tvalid, o_tdata, o_tuser, o_tlast, o_src})
	);

endmodule

`default_nettype wire

// File: logic/dual_port_packet_merge_top.sv
// Top level of the dual port packet merge
// Two async packet FIFOs feeding one round-robin merger
`timescale 1ns/100ps
`default_nettype none

module dual_port_packet_merge_top
#(
	parameter int LOG2_DEPTH = 5
) (
	input  wire i_clk,
	input  wire i_sresetn,
	input  wire i_out_clk,
	input  wire i_out_sresetn,

	// Port A, input clock domain
	input  wire             i_a_tvalid,
	output logic            o_a_tready,
	input  pkt_pkg::tdata_t i_a_tdata,
	input  pkt_pkg::tuser_t i_a_tuser,
	input  wire             i_a_tlast,
	input  wire             i_a_drop,

	// Port B, input clock domain
	input  wire             i_b_tvalid,
	output logic            o_b_tready,
	input  pkt_pkg::tdata_t i_b_tdata,
	input  pkt_pkg::tuser_t i_b_tuser,
	input  wire             i_b_tlast,
	input  wire             i_b_drop,

	// Merged output, output clock domain
	input  wire              i_tready,
	output logic             o_tvalid,
	output pkt_pkg::tdata_t  o_tdata,
	output pkt_pkg::tuser_t  o_tuser,
	output logic             o_tlast,
	output pkt_pkg::src_id_t o_src
);
	import pkt_pkg::*;

	// FIFO A read side
	logic   a_rd_tvalid;
	logic   a_rd_tready;
	tdata_t a_rd_tdata;
	tuser_t a_rd_tuser;
	logic   a_rd_tlast;

	// FIFO B read side
	logic   b_rd_tvalid;
	logic   b_rd_tready;
	tdata_t b_rd_tdata;
	tuser_t b_rd_tuser;
	logic   b_rd_tlast;

	axis_packet_fifo_async #(
		.LOG2_DEPTH(LOG2_DEPTH)
	) u_fifo_a (
		.i_clk         (i_clk),
		.i_sresetn     (i_sresetn),
		.i_tvalid      (i_a_tvalid),
		.o_tready      (o_a_tready),
		.i_tdata       (i_a_tdata),
		.i_tuser       (i_a_tuser),
		.i_tlast       (i_a_tlast),
		.i_drop        (i_a_drop),
		.i_out_clk     (i_out_clk),
		.i_out_sresetn (i_out_sresetn),
		.i_rd_tready   (a_rd_tready),
		.o_rd_tvalid   (a_rd_tvalid),
		.o_rd_tdata    (a_rd_tdata),
		.o_rd_tuser    (a_rd_tuser),
		.o_rd_tlast    (a_rd_tlast)
	);

	axis_packet_fifo_async #(
		.LOG2_DEPTH(LOG2_DEPTH)
	) u_fifo_b (
		.i_clk         (i_clk),
		.i_sresetn     (i_sresetn),
		.i_tvalid      (i_b_tvalid),
		.o_tready      (o_b_tready),
		.i_tdata       (i_b_tdata),
		.i_tuser       (i_b_tuser),
		.i_tlast       (i_b_tlast),
		.i_drop        (i_b_drop),
		.i_out_clk     (i_out_clk),
		.i_out_sresetn (i_out_sresetn),
		.i_rd_tready   (b_rd_tready),
		.o_rd_tvalid   (b_rd_tvalid),
		.o_rd_tdata    (b_rd_tdata),
		.o_rd_tuser    (b_rd_tuser),
		.o_rd_tlast    (b_rd_tlast)
	);

	// Merger runs entirely on the output clock
	axis_packet_merge u_merge (
		.i_clk      (i_out_clk),
		.i_sresetn  (i_out_sresetn),
		.i_a_tvalid (a_rd_tvalid),
		.o_a_tready (a_rd_tready),
		.i_a_tdata  (a_rd_tdata),
		.i_a_tuser  (a_rd_tuser),
		.i_a_tlast  (a_rd_tlast),
		.i_b_tvalid (b_rd_tvalid),
		.o_b_tready (b_rd_tready),
		.i_b_tdata  (b_rd_tdata),
		.i_b_tuser  (b_rd_tuser),
		.i_b_tlast  (b_rd_tlast),
		.i_tready   (i_tready),
		.o_tvalid   (o_tvalid),
		.o_tdata    (o_tdata),
		.o_tuser    (o_tuser),
		.o_tlast    (o_tlast),
		.o_src      (o_src)
	);

endmodule

`default_nettype wire

// File: testbench/tb_dual_port_packet_merge.sv
// Testbench for the dual port packet merge
// Directed tests with per-source model queues, LFSR back-pressure and a watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_dual_port_packet_merge;
	import pkt_pkg::*;

	localparam int LOG2_DEPTH = 5;
	localparam int IN_PERIOD  = 10;
	localparam int OUT_PERIOD = 14;
	// Sum of all packet lengths over every test
	localparam int TOTAL_BEATS = 120;
	localparam int WATCHDOG_NS = TOTAL_BEATS * 20 * OUT_PERIOD + 10000;
	localparam int DRAIN_LIMIT = 3000;

	logic   i_clk = 1'b0;
	logic   i_out_clk = 1'b0;
	logic   i_sresetn;
	logic   i_out_sresetn;
	logic   i_a_tvalid;
	logic   o_a_tready;
	tdata_t i_a_tdata;
	tuser_t i_a_tuser;
	logic   i_a_tlast;
	logic   i_a_drop;
	logic   i_b_tvalid;
	logic   o_b_tready;
	tdata_t i_b_tdata;
	tuser_t i_b_tuser;
	logic   i_b_tlast;
	logic   i_b_drop;
	logic    i_tready;
	logic    o_tvalid;
	tdata_t  o_tdata;
	tuser_t  o_tuser;
	logic    o_tlast;
	src_id_t o_src;

	// Expected beats per source, packed as {last, user, data}
	logic [10:0] exp_a [$];
	logic [10:0] exp_b [$];
	logic [10:0] got;
	logic [10:0] want;
	string       test_name = "reset";
	int          errors = 0;
	int          beats_checked = 0;
	// 0 holds i_tready low, 1 high, 2 random
	int          tready_mode = 1;
	logic [15:0] lfsr = 16'd40;
	logic        in_packet = 1'b0;
	src_id_t     open_src = SRC_A;

	dual_port_packet_merge_top #(
		.LOG2_DEPTH(LOG2_DEPTH)
	) dual_port_packet_merge_top_i (
		.i_clk         (i_clk),
		.i_sresetn     (i_sresetn),
		.i_out_clk     (i_out_clk),
		.i_out_sresetn (i_out_sresetn),
		.i_a_tvalid    (i_a_tvalid),
		.o_a_tready    (o_a_tready),
		.i_a_tdata     (i_a_tdata),
		.i_a_tuser     (i_a_tuser),
		.i_a_tlast     (i_a_tlast),
		.i_a_drop      (i_a_drop),
		.i_b_tvalid    (i_b_tvalid),
		.o_b_tready    (o_b_tready),
		.i_b_tdata     (i_b_tdata),
		.i_b_tuser     (i_b_tuser),
		.i_b_tlast     (i_b_tlast),
		.i_b_drop      (i_b_drop),
		.i_tready      (i_tready),
		.o_tvalid      (o_tvalid),
		.o_tdata       (o_tdata),
		.o_tuser       (o_tuser),
		.o_tlast       (o_tlast),
		.o_src         (o_src)
	);

	// Two unrelated clocks that drift against each other
	always #(IN_PERIOD / 2) i_clk = ~i_clk;
	always #(OUT_PERIOD / 2.0) i_out_clk = ~i_out_clk;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Output back-pressure, changed on the falling output edge
	always @(negedge i_out_clk)
	begin
		if (tready_mode == 2)
		begin
			lfsr = lfsr_next(lfsr);
			i_tready = lfsr[0];
		end
		else
			i_tready = (tready_mode == 1);
	end

	// Output monitor, one pop per transfer
	always @(posedge i_out_clk)
	begin
		if (i_out_sresetn && o_tvalid && i_tready)
		begin
			got = {o_tlast, o_tuser, o_tdata};
			beats_checked++;
			// No beats of the other source inside an open packet
			if (in_packet && o_src != open_src)
			begin
				errors++;
				$display("error in %s: beat from source %0d inside an open packet of source %0d",
					test_name, o_src, open_src);
			end
			if ((o_src == SRC_B) ? (exp_b.size() == 0) : (exp_a.size() == 0))
			begin
				errors++;
				$display("error in %s: unexpected beat %h from source %0d, none expected",
					test_name, got, o_src);
			end
			else
			begin
				want = (o_src == SRC_B) ? exp_b.pop_front() : exp_a.pop_front();
				if (got !== want)
				begin
					errors++;
					$display("mismatch in %s: expected %h, actual %h", test_name, want, got);
				end
			end
			in_packet = !o_tlast;
			open_src  = o_src;
		end
	end

	function automatic logic port_ready(input src_id_t port);
		return (port == SRC_B) ? o_b_tready : o_a_tready;
	endfunction

	task automatic set_port(input src_id_t port, input logic valid, input tdata_t d,
		input tuser_t u, input logic last, input logic drop);
		if (port == SRC_B)
		begin
			i_b_tvalid = valid;
			i_b_tdata  = d;
			i_b_tuser  = u;
			i_b_tlast  = last;
			i_b_drop   = drop;
		end
		else
		begin
			i_a_tvalid = valid;
			i_a_tdata  = d;
			i_a_tuser  = u;
			i_a_tlast  = last;
			i_a_drop   = drop;
		end
	endtask

	// Entered and left on a falling input edge, ready is stable there
	task automatic drive_beat(input src_id_t port, input tdata_t d, input tuser_t u,
		input logic last, input logic drop);
		set_port(port, 1'b1, d, u, last, drop);
		while (!port_ready(port))
			@(negedge i_clk);
		@(posedge i_clk);
		@(negedge i_clk);
	endtask

	// Model gets the packet only if it ended without drop
	task automatic send_packet(input src_id_t port, input int len, input tdata_t base,
		input int drop_at);
		logic [10:0] beats [$];
		tdata_t      d;
		tuser_t      u;
		logic        last;
		logic        drop;
		for (int i = 0; i < len; i++)
		begin
			d    = base + tdata_t'(i);
			u    = tuser_t'(i) ^ {1'b0, port};
			last = (i == len - 1);
			drop = (i == drop_at);
			drive_beat(port, d, u, last, drop);
			beats.push_back({last, u, d});
			if (drop)
				break;
		end
		set_port(port, 1'b0, '0, '0, 1'b0, 1'b0);
		if (drop_at < 0)
		begin
			foreach (beats[k])
			begin
				if (port == SRC_B)
					exp_b.push_back(beats[k]);
				else
					exp_a.push_back(beats[k]);
			end
		end
	endtask

	// Wait until the model queues empty, then watch for stray beats
	task automatic wait_drain;
		int cycles;
		cycles = 0;
		while ((exp_a.size() != 0 || exp_b.size() != 0) && cycles < DRAIN_LIMIT)
		begin
			@(negedge i_out_clk);
			cycles++;
		end
		if (exp_a.size() != 0 || exp_b.size() != 0)
		begin
			errors++;
			$display("error in %s: output did not drain, %0d beats of A and %0d of B missing",
				test_name, exp_a.size(), exp_b.size());
		end
		repeat (30) @(negedge i_out_clk);
		@(negedge i_clk);
	endtask

	task automatic check_reset_state;
		test_name = "reset_state";
		if (o_a_tready !== 1'b1 || o_b_tready !== 1'b1 || o_tvalid !== 1'b0)
		begin
			errors++;
			$display("error in %s: after reset both readies must be high and o_tvalid low",
				test_name);
		end
	endtask

	task automatic test_single_packet;
		test_name = "single_packet";
		send_packet(SRC_A, 6, 8'h10, -1);
		wait_drain();
	endtask

	task automatic test_drop;
		test_name = "drop";
		// Drop on the fourth beat, the rest of that packet is never sent
		send_packet(SRC_B, 5, 8'h40, 3);
		send_packet(SRC_B, 3, 8'h50, -1);
		wait_drain();
	endtask

	// Both ports busy at once, packets with small idle gaps
	task automatic test_concurrent;
		test_name = "concurrent";
		fork
			begin
				send_packet(SRC_A, 3, 8'h60, -1);
				send_packet(SRC_A, 5, 8'h68, -1);
				repeat (2) @(negedge i_clk);
				send_packet(SRC_A, 2, 8'h70, -1);
				send_packet(SRC_A, 7, 8'h78, -1);
			end
			begin
				send_packet(SRC_B, 4, 8'h80, -1);
				repeat (3) @(negedge i_clk);
				send_packet(SRC_B, 1, 8'h88, -1);
				send_packet(SRC_B, 6, 8'h90, -1);
				send_packet(SRC_B, 3, 8'h98, -1);
			end
		join
		wait_drain();
	endtask

	task automatic test_backpressure;
		test_name = "backpressure";
		tready_mode = 2;
		fork
			begin
				send_packet(SRC_A, 5, 8'ha0, -1);
				send_packet(SRC_A, 8, 8'ha8, -1);
				send_packet(SRC_A, 3, 8'hb0, -1);
				send_packet(SRC_A, 6, 8'hb8, -1);
			end
			begin
				send_packet(SRC_B, 7, 8'hc0, -1);
				send_packet(SRC_B, 2, 8'hc8, -1);
				send_packet(SRC_B, 4, 8'hd0, -1);
			end
		join
		wait_drain();
		tready_mode = 1;
	endtask

	// Fill FIFO A with the output stalled, then drain it
	task automatic test_full_fifo;
		logic [10:0] pkt [$];
		int          accepted;
		logic        full_seen;
		tdata_t      d;
		tuser_t      u;
		logic        last;
		test_name = "full_fifo";
		tready_mode = 0;
		accepted  = 0;
		full_seen = 1'b0;
		repeat (3) @(negedge i_out_clk);
		@(negedge i_clk);
		while (!full_seen && accepted < 2 ** LOG2_DEPTH + 4)
		begin
			if (!o_a_tready)
				full_seen = 1'b1;
			else
			begin
				d    = 8'he0 + tdata_t'(accepted);
				u    = tuser_t'(accepted);
				last = (accepted % 8 == 7);
				drive_beat(SRC_A, d, u, last, 1'b0);
				accepted++;
				pkt.push_back({last, u, d});
				if (last)
				begin
					foreach (pkt[k])
						exp_a.push_back(pkt[k]);
					pkt.delete();
				end
			end
		end
		set_port(SRC_A, 1'b0, '0, '0, 1'b0, 1'b0);
		if (!full_seen)
		begin
			errors++;
			$display("error in %s: port A ready still high after %0d accepted beats",
				test_name, accepted);
		end
		tready_mode = 1;
		// Complete the packet left open by the stall
		while (accepted % 8 != 0)
		begin
			d    = 8'he0 + tdata_t'(accepted);
			u    = tuser_t'(accepted);
			last = (accepted % 8 == 7);
			drive_beat(SRC_A, d, u, last, 1'b0);
			accepted++;
			pkt.push_back({last, u, d});
		end
		set_port(SRC_A, 1'b0, '0, '0, 1'b0, 1'b0);
		foreach (pkt[k])
			exp_a.push_back(pkt[k]);
		wait_drain();
	endtask

	// Watchdog sized from the total beat count
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: tests still running after %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		i_sresetn     = 1'b0;
		i_out_sresetn = 1'b0;
		i_tready      = 1'b0;
		set_port(SRC_A, 1'b0, '0, '0, 1'b0, 1'b0);
		set_port(SRC_B, 1'b0, '0, '0, 1'b0, 1'b0);
		// Each reset released after 3 cycles of its own clock
		fork
			begin
				repeat (3) @(posedge i_clk);
				@(negedge i_clk);
				i_sresetn = 1'b1;
			end
			begin
				repeat (3) @(posedge i_out_clk);
				@(negedge i_out_clk);
				i_out_sresetn = 1'b1;
			end
		join
		repeat (5) @(negedge i_clk);
		check_reset_state();
		test_single_packet();
		test_drop();
		test_concurrent();
		test_backpressure();
		test_full_fifo();
		$display("checked %0d beats, %0d errors", beats_checked, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/pkt_pkg.sv
logic/cdc_vector.sv
logic/axis_packet_fifo_async.sv
logic/axis_packet_merge.sv
logic/dual_port_packet_merge_top.sv
testbench/tb_dual_port_packet_merge.sv

// File: Bender.yml
package:
  name: dual_port_packet_merge

sources:
  # RTL in compile order
  - files:
      - logic/pkt_pkg.sv
      - logic/cdc_vector.sv
      - logic/axis_packet_fifo_async.sv
      - logic/axis_packet_merge.sv
      - logic/dual_port_packet_merge_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/tb_dual_port_packet_merge.sv
